//--- verilog/imager_cfg_pkg.sv
`default_nettype none

package imager_cfg_pkg;

	//////////////////////////////////////////////////
	// camera side
	localparam int SAMPLE_W         = 8;   // one adc sample
	localparam int PIX_W            = 24;
	localparam int SAMPLES_PER_WORD = 3;
	localparam int FRAME_WORDS      = 16;  // words per frame
	localparam int FIFO_DEPTH       = 64;
	localparam int FIFO_AW          = 6;

	//////////////////////////////////////////////////
	// mask side
	localparam int PAT_W      = 10;  // sensor mask stream width
	localparam int PAT_DEPTH  = 64;
	localparam int PAT_AW     = 6;
	localparam int MASK_DEPTH = 8;   // doubles as starting credit

	// one pixel word, raw for the fifo and host pipe
	// or split in sample lanes for the packer
	typedef union packed {
		logic [PIX_W-1:0]                          raw;
		logic [SAMPLES_PER_WORD-1:0][SAMPLE_W-1:0] lane;  // lane 0 = low byte
	} pixel_word_u;

endpackage

`default_nettype wire

//--- verilog/host_map_pkg.sv
`default_nettype none

package host_map_pkg;

	// host register addresses
	localparam logic [7:0] ADDR_CTRL   = 8'h10;
	localparam logic [7:0] ADDR_EXP    = 8'h11;  // exposure, cycles per subframe
	localparam logic [7:0] ADDR_NPAT   = 8'h12;
	localparam logic [7:0] ADDR_PDELAY = 8'h19;  // projector delay
	localparam logic [7:0] ADDR_STATUS = 8'h6A;

	// control bits, self clearing
	localparam int CTRL_RST_BIT   = 0;
	localparam int CTRL_START_BIT = 1;

	// status bits
	localparam int ST_FULL_BIT          = 0;
	localparam int ST_TWO_FRAMES_BIT    = 1;
	localparam int ST_NOT_ONE_FRAME_BIT = 2;
	localparam int ST_OVF_BIT           = 3;  // sticky

endpackage

`default_nettype wire

//--- verilog/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs (
	input  logic        CLK_HS,
	input  logic        rst_n,
	input  logic        host_wr,
	input  logic [7:0]  host_addr,
	input  logic [31:0] host_wdata,
	input  logic [7:0]  host_rd_addr,
	input  logic [3:0]  fifo_flags,
	output logic [31:0] host_rdata,
	output logic [15:0] exp_len,
	output logic [7:0]  num_pat,
	output logic [15:0] proj_delay,
	output logic        start,
	output logic        soft_rst
);
	import host_map_pkg::*;

	logic ctrl_wr;

	assign ctrl_wr = host_wr && (host_addr == ADDR_CTRL);

	// config words, kept across soft reset
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			exp_len    <= '0;
			num_pat    <= '0;
			proj_delay <= '0;
		end else if (host_wr) begin
			case (host_addr)
				ADDR_EXP:    exp_len    <= host_wdata[15:0];
				ADDR_NPAT:   num_pat    <= host_wdata[7:0];
				ADDR_PDELAY: proj_delay <= host_wdata[15:0];
				default: ;
			endcase
		end
	end

	// control word never stored, one pulse per write
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			start    <= 1'b0;
			soft_rst <= 1'b0;
		end else begin
			start    <= ctrl_wr && host_wdata[CTRL_START_BIT];
			soft_rst <= ctrl_wr && host_wdata[CTRL_RST_BIT];
		end
	end

	// readback mux
	always_comb begin
		case (host_rd_addr)
			ADDR_EXP:    host_rdata = {16'd0, exp_len};
			ADDR_NPAT:   host_rdata = {24'd0, num_pat};
			ADDR_PDELAY: host_rdata = {16'd0, proj_delay};
			ADDR_STATUS: host_rdata = {28'd0, fifo_flags};  // already in ST_ order
			default:     host_rdata = '0;  // ctrl reads back zero
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_packer (
	input  logic                                CLK_HS,
	input  logic                                rst_n,
	input  logic                                soft_rst,
	input  logic [imager_cfg_pkg::SAMPLE_W-1:0] im_data,
	input  logic                                im_data_val,
	output imager_cfg_pkg::pixel_word_u         pix_word,
	output logic                                pix_val
);
	import imager_cfg_pkg::*;

	logic [$clog2(SAMPLES_PER_WORD)-1:0] lane_cnt;  // next lane to fill
	logic                                last_lane;

	assign last_lane = (lane_cnt == SAMPLES_PER_WORD - 1);

	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			lane_cnt <= '0;
			pix_val  <= 1'b0;
		end else if (soft_rst) begin
			lane_cnt <= '0;  // drop partial word
			pix_val  <= 1'b0;
		end else begin
			pix_val <= im_data_val && last_lane;  // word complete
			if (im_data_val)
				lane_cnt <= last_lane ? '0 : lane_cnt + 1'b1;
		end
	end

	// sample k into lane k
	always_ff @(posedge CLK_HS) begin
		if (im_data_val)
			pix_word.lane[lane_cnt] <= im_data;
	end

endmodule

`default_nettype wire

//--- verilog/frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo (
	input  logic                             CLK_HS,
	input  logic                             rst_n,
	input  logic                             soft_rst,
	input  imager_cfg_pkg::pixel_word_u      pix_word,
	input  logic                             pix_val,
	input  logic                             pipe_rd,
	output logic [imager_cfg_pkg::PIX_W-1:0] pipe_data,
	output logic [3:0]                       fifo_flags
);
	import imager_cfg_pkg::*;
	import host_map_pkg::*;

	logic [PIX_W-1:0]   mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               ovf;
	logic               full;
	logic               empty;
	logic               do_wr;
	logic               do_rd;

	assign full  = (count == FIFO_DEPTH);
	assign empty = (count == '0);
	assign do_wr = pix_val && !full;  // camera never waits, word lost when full
	assign do_rd = pipe_rd && !empty;

	always_ff @(posedge CLK_HS) begin
		if (do_wr)
			mem[wr_ptr] <= pix_word.raw;
	end

	//////////////////////////////////////////////////
	// pointers, fill count, sticky overflow
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf    <= 1'b0;
		end else if (soft_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf    <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
			if (pix_val && full)
				ovf <= 1'b1;
		end
	end

	// host pipe, data one cycle after pipe_rd
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n)
			pipe_data <= '0;
		else if (pipe_rd)
			pipe_data <= empty ? '0 : mem[rd_ptr];  // empty read gives zero
	end

	always_comb begin
		fifo_flags                       = '0;
		fifo_flags[ST_FULL_BIT]          = full;
		fifo_flags[ST_TWO_FRAMES_BIT]    = (count >= 2 * FRAME_WORDS);
		fifo_flags[ST_NOT_ONE_FRAME_BIT] = (count < FRAME_WORDS);
		fifo_flags[ST_OVF_BIT]           = ovf;
	end

endmodule

`default_nettype wire

//--- verilog/pattern_store.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_store (
	input  logic                             CLK_HS,
	input  logic                             rst_n,
	input  logic                             soft_rst,
	input  logic                             pat_wr,
	input  logic [imager_cfg_pkg::PAT_W-1:0] pat_wdata,
	input  logic                             start,
	input  logic [7:0]                       num_pat,
	input  logic                             credit_ret,
	output logic                             pat_push,
	output logic [imager_cfg_pkg::PAT_W-1:0] pat_data
);
	import imager_cfg_pkg::*;

	logic [PAT_W-1:0]            ram [PAT_DEPTH];
	logic [PAT_AW-1:0]           wr_addr;  // host fill pointer
	logic [7:0]                  rd_cnt;   // patterns sent this run
	logic                        active;
	logic [$clog2(MASK_DEPTH):0] credit;   // free slots in mask fifo

	always_ff @(posedge CLK_HS) begin
		if (pat_wr)
			ram[wr_addr] <= pat_wdata;
	end

	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n)
			wr_addr <= '0;
		else if (soft_rst)
			wr_addr <= '0;
		else if (pat_wr)
			wr_addr <= wr_addr + 1'b1;
	end

	assign pat_push = active && (credit != '0);
	assign pat_data = ram[rd_cnt[PAT_AW-1:0]];  // async read of next entry

	//////////////////////////////////////////////////
	// streaming from address 0, one per cycle while credit lasts
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			rd_cnt <= '0;
		end else if (soft_rst) begin
			active <= 1'b0;
			rd_cnt <= '0;
		end else if (start && !active) begin
			active <= (num_pat != 8'd0);
			rd_cnt <= '0;
		end else if (pat_push) begin
			rd_cnt <= rd_cnt + 8'd1;
			if (rd_cnt == num_pat - 8'd1)
				active <= 1'b0;  // last one out
		end
	end

	// credit, spent on push and returned on pop
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n)
			credit <= MASK_DEPTH[$clog2(MASK_DEPTH):0];
		else if (soft_rst)
			credit <= MASK_DEPTH[$clog2(MASK_DEPTH):0];
		else begin
			case ({pat_push, credit_ret})
				2'b10:   credit <= credit - 1'b1;
				2'b01:   credit <= credit + 1'b1;
				default: ;  // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/mask_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mask_fifo (
	input  logic                             CLK_HS,
	input  logic                             rst_n,
	input  logic                             soft_rst,
	input  logic                             pat_push,
	input  logic [imager_cfg_pkg::PAT_W-1:0] pat_data,
	input  logic                             stream,
	output logic [imager_cfg_pkg::PAT_W-1:0] mstream,
	output logic                             mask_empty,
	output logic                             credit_ret
);
	import imager_cfg_pkg::*;

	logic [PAT_W-1:0]              mem [MASK_DEPTH];
	logic [$clog2(MASK_DEPTH)-1:0] wr_ptr;
	logic [$clog2(MASK_DEPTH)-1:0] rd_ptr;
	logic [$clog2(MASK_DEPTH):0]   count;
	logic                          pop;

	assign mask_empty = (count == '0);
	assign pop        = stream && !mask_empty;
	assign credit_ret = pop;  // slot goes back to the store

	// no full check, the store never pushes without credit
	always_ff @(posedge CLK_HS) begin
		if (pat_push)
			mem[wr_ptr] <= pat_data;
	end

	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			mstream <= '0;
		end else if (soft_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (pat_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr  <= rd_ptr + 1'b1;
				mstream <= mem[rd_ptr];  // head to the sensor
			end
			case ({pat_push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/exposure_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module exposure_fsm (
	input  logic        CLK_HS,
	input  logic        rst_n,
	input  logic        soft_rst,
	input  logic        start,
	input  logic [15:0] exp_len,
	input  logic [7:0]  num_pat,
	input  logic [15:0] proj_delay,
	input  logic        mask_empty,
	output logic        stream,
	output logic        pixres_glob,
	output logic        drain_b,
	output logic        trigger_proj,
	output logic        fsm_done,
	output logic [7:0]  led
);

	typedef enum logic [1:0] {
		S_IDLE   = 2'd0,
		S_WAIT   = 2'd1,  // holding for a mask pattern
		S_EXPOSE = 2'd2,
		S_DRAIN  = 2'd3
	} state_t;

	state_t      state;
	logic [15:0] cyc_cnt;  // cycle within subframe
	logic [7:0]  sub_idx;  // subframe index
	logic        sub_last;
	logic        pat_last;

	assign sub_last = (exp_len == 16'd0) || (cyc_cnt == exp_len - 16'd1);
	assign pat_last = (sub_idx == num_pat - 8'd1);

	//////////////////////////////////////////////////
	// sensor and projector strobes
	assign pixres_glob  = (state == S_EXPOSE) && (cyc_cnt == 16'd0);  // first cycle
	assign stream       = pixres_glob;  // pop, mstream moves next edge
	assign trigger_proj = (state == S_EXPOSE) && (cyc_cnt == proj_delay);
	assign drain_b      = (state != S_DRAIN);  // active low
	assign led          = {sub_idx[5:0], state};

	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			cyc_cnt  <= '0;
			sub_idx  <= '0;
			fsm_done <= 1'b0;
		end else if (soft_rst) begin
			state    <= S_IDLE;
			cyc_cnt  <= '0;
			sub_idx  <= '0;
			fsm_done <= 1'b0;
		end else begin
			fsm_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						cyc_cnt <= '0;
						sub_idx <= '0;
						state   <= (num_pat == 8'd0) ? S_DRAIN : S_WAIT;
					end
				end
				S_WAIT: begin
					if (!mask_empty) begin
						cyc_cnt <= '0;
						state   <= S_EXPOSE;
					end
				end
				S_EXPOSE: begin
					if (sub_last) begin
						cyc_cnt <= '0;
						if (pat_last)
							state <= S_DRAIN;
						else begin
							sub_idx <= sub_idx + 8'd1;
							if (mask_empty)
								state <= S_WAIT;  // no pattern yet, hold
						end
					end else
						cyc_cnt <= cyc_cnt + 16'd1;
				end
				S_DRAIN: begin
					fsm_done <= 1'b1;  // one cycle after drain
					state    <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/imager_top.sv
`timescale 1ns/1ps
`default_nettype none

module imager_top (
	input  logic                                CLK_HS,
	input  logic                                rst_n,
	input  logic                                host_wr,
	input  logic [7:0]                          host_addr,
	input  logic [31:0]                         host_wdata,
	input  logic [7:0]                          host_rd_addr,
	output logic [31:0]                         host_rdata,
	input  logic [imager_cfg_pkg::SAMPLE_W-1:0] im_data,
	input  logic                                im_data_val,
	input  logic                                pipe_rd,
	output logic [imager_cfg_pkg::PIX_W-1:0]    pipe_data,
	input  logic                                pat_wr,
	input  logic [imager_cfg_pkg::PAT_W-1:0]    pat_wdata,
	output logic [imager_cfg_pkg::PAT_W-1:0]    mstream,
	output logic                                stream,
	output logic                                pixres_glob,
	output logic                                drain_b,
	output logic                                trigger_proj,
	output logic [7:0]                          led
);
	import imager_cfg_pkg::*;

	// host config
	logic [15:0]      exp_len;
	logic [7:0]       num_pat;
	logic [15:0]      proj_delay;
	logic             start;
	logic             soft_rst;
	logic [3:0]       fifo_flags;
	// pixel path
	pixel_word_u      pix_word;
	logic             pix_val;
	// mask path
	logic             pat_push;
	logic [PAT_W-1:0] pat_data;
	logic             credit_ret;
	logic             mask_empty;
	logic             fsm_done;  // end of run, one cycle after drain

	host_regs u_regs (
		.CLK_HS(CLK_HS), .rst_n(rst_n),
		.host_wr(host_wr), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_rd_addr(host_rd_addr), .fifo_flags(fifo_flags), .host_rdata(host_rdata),
		.exp_len(exp_len), .num_pat(num_pat), .proj_delay(proj_delay),
		.start(start), .soft_rst(soft_rst)
	);

	//////////////////////////////////////////////////
	// camera to host
	pixel_packer u_packer (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .soft_rst(soft_rst),
		.im_data(im_data), .im_data_val(im_data_val),
		.pix_word(pix_word), .pix_val(pix_val)
	);

	frame_fifo u_frame_fifo (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .soft_rst(soft_rst),
		.pix_word(pix_word), .pix_val(pix_val),
		.pipe_rd(pipe_rd), .pipe_data(pipe_data), .fifo_flags(fifo_flags)
	);

	//////////////////////////////////////////////////
	// host patterns to sensor mask
	pattern_store u_pat_store (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .soft_rst(soft_rst),
		.pat_wr(pat_wr), .pat_wdata(pat_wdata),
		.start(start), .num_pat(num_pat), .credit_ret(credit_ret),
		.pat_push(pat_push), .pat_data(pat_data)
	);

	mask_fifo u_mask_fifo (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .soft_rst(soft_rst),
		.pat_push(pat_push), .pat_data(pat_data), .stream(stream),
		.mstream(mstream), .mask_empty(mask_empty), .credit_ret(credit_ret)
	);

	exposure_fsm u_exp_fsm (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .soft_rst(soft_rst),
		.start(start), .exp_len(exp_len), .num_pat(num_pat),
		.proj_delay(proj_delay), .mask_empty(mask_empty),
		.stream(stream), .pixres_glob(pixres_glob), .drain_b(drain_b),
		.trigger_proj(trigger_proj), .fsm_done(fsm_done), .led(led)
	);

endmodule

`default_nettype wire

//--- verif/imager_tb_table.svh
`ifndef IMAGER_TB_TABLE_SVH
`define IMAGER_TB_TABLE_SVH

// step kinds for the table walk
typedef enum logic [2:0] {
	STEP_WRITE,  // host register write
	STEP_READ,   // host register read and compare
	STEP_PUSH,   // camera samples, count in words
	STEP_PIPE,   // pipe reads, count in words
	STEP_PAT,    // pattern pipe-in, count in patterns
	STEP_RUN,    // start, then follow the exposure to the drain pulse
	STEP_WAIT    // idle cycles
} step_kind_e;

typedef struct packed {
	logic [3:0]  test;   // index into test_names
	step_kind_e  kind;
	logic [7:0]  addr;
	logic [31:0] data;   // write data or expected readback
	logic [15:0] count;
	logic [15:0] bound;  // cycle limit of the step
} step_t;

localparam int NUM_STEPS = 22;
localparam int MAX_BOUND = 250;  // longest bound below

// expected status words
localparam logic [31:0] ST_EMPTY   = 32'(1) << ST_NOT_ONE_FRAME_BIT;
localparam logic [31:0] ST_TWO     = 32'(1) << ST_TWO_FRAMES_BIT;
localparam logic [31:0] ST_OVERRUN = (32'(1) << ST_FULL_BIT) | ST_TWO | (32'(1) << ST_OVF_BIT);

step_t steps [NUM_STEPS];
string test_names [1:5];

function automatic step_t make_step(input int test, input step_kind_e kind,
		input logic [7:0] addr, input logic [31:0] data, input int count, input int bound);
	step_t s;
	s.test  = test[3:0];
	s.kind  = kind;
	s.addr  = addr;
	s.data  = data;
	s.count = count[15:0];
	s.bound = bound[15:0];
	return s;
endfunction

task automatic load_table();
	test_names[1] = "register readback";
	test_names[2] = "pixel packing";
	test_names[3] = "frame flags";
	test_names[4] = "pattern order";
	test_names[5] = "projector timing";
	steps[0]  = make_step(1, STEP_READ,  ADDR_STATUS, ST_EMPTY, 0, 4);
	steps[1]  = make_step(1, STEP_WRITE, ADDR_EXP,    32'd6, 0, 4);
	steps[2]  = make_step(1, STEP_WRITE, ADDR_NPAT,   32'd12, 0, 4);  // above mask depth
	steps[3]  = make_step(1, STEP_WRITE, ADDR_PDELAY, 32'd3, 0, 4);
	steps[4]  = make_step(1, STEP_READ,  ADDR_EXP,    32'd6, 0, 4);
	steps[5]  = make_step(1, STEP_READ,  ADDR_NPAT,   32'd12, 0, 4);
	steps[6]  = make_step(1, STEP_READ,  ADDR_PDELAY, 32'd3, 0, 4);
	steps[7]  = make_step(2, STEP_PUSH,  8'h00, 32'd0, 4, 40);
	steps[8]  = make_step(2, STEP_PIPE,  8'h00, 32'd0, 5, 20);  // last read on empty
	steps[9]  = make_step(3, STEP_PUSH,  8'h00, 32'd0, 2 * FRAME_WORDS, 120);
	steps[10] = make_step(3, STEP_READ,  ADDR_STATUS, ST_TWO, 0, 4);
	steps[11] = make_step(3, STEP_PUSH,  8'h00, 32'd0, FIFO_DEPTH - 2 * FRAME_WORDS + 1, 120);
	steps[12] = make_step(3, STEP_READ,  ADDR_STATUS, ST_OVERRUN, 0, 4);
	steps[13] = make_step(3, STEP_WRITE, ADDR_CTRL,   32'(1) << CTRL_RST_BIT, 0, 4);
	steps[14] = make_step(3, STEP_READ,  ADDR_STATUS, ST_EMPTY, 0, 4);
	steps[15] = make_step(4, STEP_PAT,   8'h00, 32'd0, 12, 20);
	steps[16] = make_step(4, STEP_RUN,   8'h00, 32'd0, 0, 200);
	steps[17] = make_step(4, STEP_WAIT,  8'h00, 32'd0, 4, 4);
	steps[18] = make_step(5, STEP_WRITE, ADDR_EXP,    32'd9, 0, 4);
	steps[19] = make_step(5, STEP_WRITE, ADDR_PDELAY, 32'd7, 0, 4);
	steps[20] = make_step(5, STEP_RUN,   8'h00, 32'd0, 0, MAX_BOUND);  // same patterns again
	steps[21] = make_step(5, STEP_WAIT,  8'h00, 32'd0, 4, 4);
endtask

`endif

//--- verif/imager_tb.sv
`timescale 1ns/1ps
`default_nettype none

module imager_tb;
	import imager_cfg_pkg::*;
	import host_map_pkg::*;

	localparam int          CLK_PERIOD = 40;
	localparam int          DRIVE_DLY  = 2;   // input skew after the rising edge
	localparam int          RST_CYCLES = 5;
	localparam logic [31:0] RAND_SEED  = 32'h2e78;

	// state codes of idle, wait, expose and drain, in that order
	localparam logic [1:0]  LED_EXPOSE = 2'd2;
	localparam logic [1:0]  LED_DRAIN  = 2'd3;

	`include "imager_tb_table.svh"

	localparam int WATCHDOG_NS = (NUM_STEPS * MAX_BOUND + RST_CYCLES + 2) * CLK_PERIOD;

	logic                CLK_HS;
	logic                rst_n;
	logic                host_wr;
	logic [7:0]          host_addr;
	logic [31:0]         host_wdata;
	logic [7:0]          host_rd_addr;
	logic [31:0]         host_rdata;
	logic [SAMPLE_W-1:0] im_data;
	logic                im_data_val;
	logic                pipe_rd;
	logic [PIX_W-1:0]    pipe_data;
	logic                pat_wr;
	logic [PAT_W-1:0]    pat_wdata;
	logic [PAT_W-1:0]    mstream;
	logic                stream;
	logic                pixres_glob;
	logic                drain_b;
	logic                trigger_proj;
	logic [7:0]          led;

	// reference model state
	logic [PIX_W-1:0] word_q [$];           // words the frame fifo should hold
	logic [PAT_W-1:0] pat_model [PAT_DEPTH];
	int               pat_wr_idx;
	int               m_exp_len;
	int               m_num_pat;
	int               m_proj_delay;
	// bookkeeping
	int               checks;
	int               errors;
	int               test_checks;
	int               test_errs;
	int               cur_test;
	int               seed_val;

	imager_top UUT (.*);

	initial begin
		CLK_HS = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_HS = ~CLK_HS;
	end

	// hard stop, sized from the step table
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the step table never finished", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	task automatic next_cycle();
		@(posedge CLK_HS);
		#(DRIVE_DLY);  // drive and sample point
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			errors++;
			test_errs++;
			$display("ERROR @%0t ns: %s got 'h%0h, expected 'h%0h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s: %0d checks, %0d errors", t, test_names[t], test_checks, test_errs);
		test_checks = 0;
		test_errs   = 0;
	endtask

	//////////////////////////////////////////////////
	// host register bus
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		host_wr    = 1'b1;
		host_addr  = addr;
		host_wdata = data;
		next_cycle();
		host_wr    = 1'b0;
		host_wdata = '0;
		case (addr)  // mirror of the register map
			ADDR_EXP:    m_exp_len    = int'(data[15:0]);
			ADDR_NPAT:   m_num_pat    = int'(data[7:0]);
			ADDR_PDELAY: m_proj_delay = int'(data[15:0]);
			ADDR_CTRL: begin
				if (data[CTRL_RST_BIT]) begin
					word_q.delete();  // soft reset empties the fifo
					pat_wr_idx = 0;
				end
			end
			default: ;
		endcase
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp);
		host_rd_addr = addr;
		next_cycle();
		check_value($sformatf("read of 'h%0h", addr), host_rdata, exp);
	endtask

	//////////////////////////////////////////////////
	// camera in, pipe out
	task automatic push_samples(input int n_words);
		logic [31:0]      rnd;
		logic [PIX_W-1:0] word;
		for (int w = 0; w < n_words; w++) begin
			for (int k = 0; k < SAMPLES_PER_WORD; k++) begin
				rnd  = $urandom;
				word[k*SAMPLE_W +: SAMPLE_W] = rnd[SAMPLE_W-1:0];  // sample k to byte k
				im_data     = rnd[SAMPLE_W-1:0];
				im_data_val = 1'b1;
				next_cycle();
			end
			if (word_q.size() < FIFO_DEPTH)
				word_q.push_back(word);  // otherwise dropped
		end
		im_data_val = 1'b0;
		repeat (4) next_cycle();  // packer plus fifo write latency
	endtask

	task automatic pipe_read(input int n_words);
		logic [PIX_W-1:0] exp_word;
		pipe_rd = 1'b1;
		for (int i = 0; i < n_words; i++) begin
			next_cycle();
			if (word_q.size() > 0)
				exp_word = word_q.pop_front();
			else
				exp_word = '0;  // empty read
			check_value("pipe_data", 32'(pipe_data), 32'(exp_word));
		end
		pipe_rd = 1'b0;
	endtask

	task automatic write_patterns(input int n_pat);
		logic [31:0] rnd;
		for (int i = 0; i < n_pat; i++) begin
			rnd       = $urandom;
			pat_wdata = rnd[PAT_W-1:0];
			pat_wr    = 1'b1;
			pat_model[pat_wr_idx] = rnd[PAT_W-1:0];
			pat_wr_idx = (pat_wr_idx + 1) % PAT_DEPTH;
			next_cycle();
		end
		pat_wr = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// one exposure run, start to fsm_done
	task automatic run_exposure(input int bound);
		int   cyc;
		int   n_stream;
		int   n_trig;
		int   n_drain;
		int   last_pix;
		logic prev_stream;
		logic prev_drain;
		logic finished;
		cyc         = 0;
		n_stream    = 0;
		n_trig      = 0;
		n_drain     = 0;
		last_pix    = 0;
		prev_stream = 1'b0;
		prev_drain  = 1'b1;
		finished    = 1'b0;
		write_reg(ADDR_CTRL, 32'(1) << CTRL_START_BIT);
		while (!finished && cyc < bound) begin
			next_cycle();
			cyc++;
			if (prev_stream)  // popped at the edge just passed
				check_value("mstream after pop", 32'(mstream), 32'(pat_model[n_stream-1]));
			check_value("stream vs pixres_glob", 32'(stream), 32'(pixres_glob));
			if (pixres_glob) begin
				if (n_stream > 0)
					check_value("pixres_glob spacing", cyc - last_pix, m_exp_len);
				check_value("led in subframe", 32'(led), 32'({6'(n_stream), LED_EXPOSE}));
				last_pix = cyc;
			end
			if (stream)
				n_stream++;
			if (trigger_proj) begin
				n_trig++;
				check_value("trigger_proj delay", cyc - last_pix, m_proj_delay);
			end
			if (UUT.fsm_done) begin
				finished = 1'b1;  // run over
				check_value("drain_b low before fsm_done", 32'(prev_drain), 32'd0);
			end
			if (!drain_b) begin
				n_drain++;
				check_value("stream pulses before drain", n_stream, m_num_pat);
				check_value("led in drain", 32'(led), 32'({6'(m_num_pat - 1), LED_DRAIN}));
			end
			prev_stream = stream;
			prev_drain  = drain_b;
		end
		checks++;
		test_checks++;
		assert (finished) else begin
			errors++;
			test_errs++;
			$display("exposure run did not reach fsm_done within %0d cycles", bound);
		end
		check_value("drain_b low cycles", n_drain, 32'd1);
		check_value("trigger_proj pulses", n_trig, m_num_pat);
	endtask

	//////////////////////////////////////////////////
	// table walk
	initial begin
		seed_val     = $urandom(RAND_SEED);
		rst_n        = 1'b0;
		host_wr      = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;
		host_rd_addr = '0;
		im_data      = '0;
		im_data_val  = 1'b0;
		pipe_rd      = 1'b0;
		pat_wr       = 1'b0;
		pat_wdata    = '0;
		pat_wr_idx   = 0;
		m_exp_len    = 0;
		m_num_pat    = 0;
		m_proj_delay = 0;
		checks       = 0;
		errors       = 0;
		test_checks  = 0;
		test_errs    = 0;
		cur_test     = 0;
		load_table();
		repeat (RST_CYCLES) @(posedge CLK_HS);
		#(DRIVE_DLY) rst_n = 1'b1;
		next_cycle();
		for (int i = 0; i < NUM_STEPS; i++) begin
			if (int'(steps[i].test) != cur_test) begin
				if (cur_test != 0)
					report_test(cur_test);
				cur_test = int'(steps[i].test);
			end
			case (steps[i].kind)
				STEP_WRITE: write_reg(steps[i].addr, steps[i].data);
				STEP_READ:  read_reg(steps[i].addr, steps[i].data);
				STEP_PUSH:  push_samples(int'(steps[i].count));
				STEP_PIPE:  pipe_read(int'(steps[i].count));
				STEP_PAT:   write_patterns(int'(steps[i].count));
				STEP_RUN:   run_exposure(int'(steps[i].bound));
				STEP_WAIT:  repeat (int'(steps[i].count)) next_cycle();
				default:    ;
			endcase
		end
		report_test(cur_test);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
verilog/imager_cfg_pkg.sv
verilog/host_map_pkg.sv
verilog/host_regs.sv
verilog/pixel_packer.sv
verilog/frame_fifo.sv
verilog/pattern_store.sv
verilog/mask_fifo.sv
verilog/exposure_fsm.sv
verilog/imager_top.sv
verif/imager_tb.sv
